// ==== common/lambda_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Q8.8 fixed point throughout; slice table only covers softplus on [-4,4)
// Latency constants must match the stage counts in the RTL
//////////////////////////////////////////////////////////////////////
`default_nettype none

package lambda_pkg;

    localparam int FRAC_BITS    = 8;
    localparam int SOFTPLUS_LAT = 2;
    localparam int SQRT_LAT     = 12;
    // Input reg, softplus, sqrt, multiply, add/output
    localparam int TOTAL_LAT    = 1 + SOFTPLUS_LAT + SQRT_LAT + 1 + 1;

    // AXI4-Lite register map
    localparam int AXIL_ADDR_W = 4;
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL  = 4'h0;  // bit 0 noise_en
    localparam logic [AXIL_ADDR_W-1:0] REG_SEED  = 4'h4;  // Write reloads the LFSR
    localparam logic [AXIL_ADDR_W-1:0] REG_COUNT = 4'h8;  // Read only

    localparam logic [15:0] LFSR_TAPS = 16'hB400;  // x^16+x^14+x^13+x^11+1

    // Secant lines through softplus at the slice ends, index 0 is [-4,-3)
    localparam logic signed [15:0] SP_SLOPE [8] = '{
        16'sh0008, 16'sh0014, 16'sh0030, 16'sh0061,
        16'sh009F, 16'sh00D0, 16'sh00EC, 16'sh00F8
    };
    localparam logic signed [15:0] SP_ICEPT [8] = '{
        16'sh0024, 16'sh0049, 16'sh0080, 16'sh00B1,
        16'sh00B1, 16'sh0080, 16'sh0049, 16'sh0024
    };

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_DATA
    } axil_state_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

endpackage

`default_nettype wire

// ==== hdl/lambda_ctrl_regs.sv ====
//////////////////////////////////////////////////////////////////////
// Master must present awvalid and wvalid together; write wins a tie
// REG_SEED reads back as written, a stored 0 drives RESET_SEED out
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lambda_ctrl_regs #(
    parameter logic [15:0] RESET_SEED = 16'hACE1
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire [lambda_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr,
    input  wire                               s_axil_awvalid,
    output logic                              s_axil_awready,
    input  wire [31:0]                        s_axil_wdata,
    input  wire [3:0]                         s_axil_wstrb,
    input  wire                               s_axil_wvalid,
    output logic                              s_axil_wready,
    output logic [1:0]                        s_axil_bresp,
    output logic                              s_axil_bvalid,
    input  wire                               s_axil_bready,
    input  wire [lambda_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
    input  wire                               s_axil_arvalid,
    output logic                              s_axil_arready,
    output logic [31:0]                       s_axil_rdata,
    output logic [1:0]                        s_axil_rresp,
    output logic                              s_axil_rvalid,
    input  wire                               s_axil_rready,
    input  wire                               out_valid,
    output logic                              noise_en,
    output logic [15:0]                       seed_value,
    output logic                              seed_load
);
    import lambda_pkg::*;

    axil_state_e state;
    logic        wr_req;
    logic        rd_req;
    logic        wr_ok;
    logic [15:0] seed_q;
    logic [31:0] count_q;
    logic [31:0] rd_word;

    assign wr_req = (state == IDLE) && s_axil_awvalid && s_axil_wvalid;
    assign rd_req = (state == IDLE) && s_axil_arvalid && !wr_req;
    assign wr_ok  = (s_axil_awaddr == REG_CTRL) || (s_axil_awaddr == REG_SEED);

    assign s_axil_awready = (state == IDLE);
    assign s_axil_wready  = (state == IDLE);
    assign s_axil_arready = (state == IDLE) && !(s_axil_awvalid && s_axil_wvalid);
    assign s_axil_bvalid  = (state == WRITE_RESP);
    assign s_axil_rvalid  = (state == READ_DATA);
    assign s_axil_rresp   = OKAY;  // Every read answers, unmapped ones with zero

    assign seed_value = (seed_q == 16'h0) ? RESET_SEED : seed_q;  // Zero would lock the LFSR

    always_comb begin
        case (s_axil_araddr)
            REG_CTRL:  rd_word = {31'b0, noise_en};
            REG_SEED:  rd_word = {16'b0, seed_q};
            REG_COUNT: rd_word = count_q;
            default:   rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            noise_en  <= 1'b0;
            seed_q    <= RESET_SEED;
            seed_load <= 1'b0;
            count_q   <= '0;
        end else begin
            seed_load <= wr_req && (s_axil_awaddr == REG_SEED);
            if (out_valid) begin
                count_q <= count_q + 32'd1;
            end
            case (state)
                IDLE: begin
                    if (wr_req) begin
                        state <= WRITE_RESP;
                        if (s_axil_awaddr == REG_CTRL && s_axil_wstrb[0]) begin
                            noise_en <= s_axil_wdata[0];
                        end
                        if (s_axil_awaddr == REG_SEED) begin
                            if (s_axil_wstrb[0]) seed_q[7:0]  <= s_axil_wdata[7:0];
                            if (s_axil_wstrb[1]) seed_q[15:8] <= s_axil_wdata[15:8];
                        end
                    end else if (rd_req) begin
                        state <= READ_DATA;
                    end
                end
                WRITE_RESP: if (s_axil_bready) state <= IDLE;
                READ_DATA:  if (s_axil_rready) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    // Response payload, captured on acceptance
    always_ff @(posedge clk) begin
        if (wr_req) begin
            s_axil_bresp <= wr_ok ? OKAY : SLVERR;  // REG_COUNT and holes reject
        end
        if (rd_req) begin
            s_axil_rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gauss_lfsr.sv ====
//////////////////////////////////////////////////////////////////////
// Uniform noise only, no Gaussian shaping; seed must be nonzero
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module gauss_lfsr #(
    parameter logic [15:0] RESET_SEED = 16'hACE1
) (
    input  wire        clk,
    input  wire        reset,
    input  wire        step,
    input  wire        seed_load,
    input  wire [15:0] seed_value,
    output logic [15:0] eps_raw
);
    import lambda_pkg::*;

    logic [15:0] state_next;

    // Galois form, shift right and fold taps in when bit 0 falls out
    assign state_next = {1'b0, eps_raw[15:1]} ^ (eps_raw[0] ? LFSR_TAPS : 16'h0);

    always_ff @(posedge clk) begin
        if (reset) begin
            eps_raw <= RESET_SEED;
        end else if (seed_load) begin     // Reload beats a step in the same cycle
            eps_raw <= seed_value;
        end else if (step) begin
            eps_raw <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== reparam/softplus_slices.sv ====
//////////////////////////////////////////////////////////////////////
// Q8.8 in and out, two cycles; below -4.0 gives 0, 4.0 and up pass through
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module softplus_slices (
    input  wire        clk,
    input  wire        reset,
    input  wire        in_valid,
    input  wire [15:0] data_in,
    output logic       out_valid,
    output logic [15:0] data_out
);
    import lambda_pkg::*;

    localparam logic signed [15:0] X_LIM = 16'(4 << FRAC_BITS);  // 4.0

    logic signed [15:0] x_in;
    logic               v1_q;
    logic signed [15:0] x_q;
    logic [2:0]         idx_q;
    logic               below_q;
    logic               above_q;
    logic signed [31:0] lin_prod;
    logic signed [31:0] lin_val;

    assign x_in = $signed(data_in);

    always_ff @(posedge clk) begin
        if (reset) begin
            v1_q      <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            v1_q      <= in_valid;
            out_valid <= v1_q;
        end
    end

    // Stage one picks the slice
    always_ff @(posedge clk) begin
        x_q     <= x_in;
        below_q <= (x_in < -X_LIM);
        above_q <= (x_in >= X_LIM);
        idx_q   <= {~data_in[10], data_in[9:8]};  // Integer part plus 4
    end

    assign lin_prod = SP_SLOPE[idx_q] * x_q;
    assign lin_val  = (lin_prod >>> FRAC_BITS) + SP_ICEPT[idx_q];

    // Stage two evaluates the line
    always_ff @(posedge clk) begin
        if (below_q) begin
            data_out <= '0;
        end else if (above_q) begin
            data_out <= x_q;  // softplus(x) ~ x up here
        end else if (lin_val < 0) begin
            data_out <= '0;
        end else begin
            data_out <= lin_val[15:0];
        end
    end

endmodule

`default_nettype wire

// ==== reparam/sqrt_pipe.sv ====
//////////////////////////////////////////////////////////////////////
// Floor sqrt of a non-negative Q8.8 value, one result bit per stage
// Result never exceeds 0x0FFF since the input is at most 0x7FFF
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sqrt_pipe (
    input  wire        clk,
    input  wire        reset,
    input  wire        in_valid,
    input  wire [15:0] data_in,
    output logic       out_valid,
    output logic [15:0] data_out
);
    import lambda_pkg::*;

    localparam int RW = 16 + FRAC_BITS;  // Radicand width

    wire [RW-1:0]       rem_w  [0:SQRT_LAT];
    wire [SQRT_LAT-1:0] root_w [0:SQRT_LAT];
    logic [SQRT_LAT:1]  valid_q;

    // Shift left by FRAC_BITS so the root lands back in Q8.8
    assign rem_w[0]  = {data_in, {FRAC_BITS{1'b0}}};
    assign root_w[0] = '0;

    for (genvar s = 0; s < SQRT_LAT; s++) begin : g_stage
        localparam int B = SQRT_LAT - 1 - s;  // Result bit settled here

        logic [RW+1:0]       delta;
        logic [RW-1:0]       rem_q;
        logic [SQRT_LAT-1:0] root_q;

        // (root + 2^B)^2 - root^2
        assign delta = ({{(RW+2-SQRT_LAT){1'b0}}, root_w[s]} << (B + 1))
                     + ((RW+2)'(1) << (2 * B));

        always_ff @(posedge clk) begin
            if ({2'b00, rem_w[s]} >= delta) begin
                rem_q  <= rem_w[s] - delta[RW-1:0];
                root_q <= root_w[s] | (SQRT_LAT'(1) << B);
            end else begin
                rem_q  <= rem_w[s];
                root_q <= root_w[s];
            end
        end

        assign rem_w[s+1]  = rem_q;
        assign root_w[s+1] = root_q;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[SQRT_LAT-1:1], in_valid};
        end
    end

    assign out_valid = valid_q[SQRT_LAT];
    assign data_out  = {{(16-SQRT_LAT){1'b0}}, root_w[SQRT_LAT]};

endmodule

`default_nettype wire

// ==== reparam/reparam_core.sv ====
//////////////////////////////////////////////////////////////////////
// Expects mean one cycle before the LFSR step lands; sigma 14 cycles later
// Output saturates to signed Q8.8, two cycles after sigma
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module reparam_core (
    input  wire        clk,
    input  wire        reset,
    input  wire        in_valid,
    input  wire [15:0] mean_in,
    input  wire [15:0] eps_raw,
    input  wire        noise_en,
    input  wire        sig_valid,
    input  wire [15:0] sigma,
    output logic       out_valid,
    output logic [15:0] out_lambda
);
    import lambda_pkg::*;

    // Mean is consumed at the add, eps at the multiply one cycle earlier
    localparam int MEAN_DEPTH = 1 + SOFTPLUS_LAT + SQRT_LAT;
    localparam int EPS_DEPTH  = SOFTPLUS_LAT + SQRT_LAT - 1;  // Enters a cycle late too
    localparam int EPS_SHIFT  = 5;                            // eps in [-4,4)
    localparam logic signed [32:0] SAT_MAX = 33'sd32767;
    localparam logic signed [32:0] SAT_MIN = -33'sd32768;

    logic [15:0]        mean_dly [MEAN_DEPTH];
    logic signed [15:0] eps_dly  [EPS_DEPTH];
    logic               eps_take_q;
    logic signed [15:0] eps_scaled;
    logic signed [31:0] prod_q;
    logic               prod_valid_q;
    logic signed [32:0] sum;
    logic [15:0]        lambda_sat;

    assign eps_scaled = $signed(eps_raw) >>> EPS_SHIFT;

    always_ff @(posedge clk) begin
        if (reset) begin
            eps_take_q   <= 1'b0;
            prod_valid_q <= 1'b0;
            out_valid    <= 1'b0;
        end else begin
            eps_take_q   <= in_valid;  // LFSR holds the new state now
            prod_valid_q <= sig_valid;
            out_valid    <= prod_valid_q;
        end
    end

    assign sum = $signed(mean_dly[MEAN_DEPTH-1]) + prod_q;

    always_comb begin
        if (sum > SAT_MAX) begin
            lambda_sat = 16'h7FFF;
        end else if (sum < SAT_MIN) begin
            lambda_sat = 16'h8000;
        end else begin
            lambda_sat = sum[15:0];
        end
    end

    always_ff @(posedge clk) begin
        mean_dly[0] <= mean_in;
        eps_dly[0]  <= (eps_take_q && noise_en) ? eps_scaled : '0;
        for (int i = 1; i < MEAN_DEPTH; i++) begin
            mean_dly[i] <= mean_dly[i-1];
        end
        for (int i = 1; i < EPS_DEPTH; i++) begin
            eps_dly[i] <= eps_dly[i-1];
        end
        prod_q     <= ($signed({1'b0, sigma}) * eps_dly[EPS_DEPTH-1]) >>> FRAC_BITS;
        out_lambda <= lambda_sat;
    end

endmodule

`default_nettype wire

// ==== hdl/lambda_layer_top.sv ====
//////////////////////////////////////////////////////////////////////
// Valid-only sample stream, no back-pressure; AXI4-Lite for config only
// out_valid follows a sampled in_valid by TOTAL_LAT cycles
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lambda_layer_top #(
    parameter logic [15:0] RESET_SEED = 16'hACE1
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire [lambda_pkg::AXIL_ADDR_W-1:0] s_axil_awaddr,
    input  wire                               s_axil_awvalid,
    output logic                              s_axil_awready,
    input  wire [31:0]                        s_axil_wdata,
    input  wire [3:0]                         s_axil_wstrb,
    input  wire                               s_axil_wvalid,
    output logic                              s_axil_wready,
    output logic [1:0]                        s_axil_bresp,
    output logic                              s_axil_bvalid,
    input  wire                               s_axil_bready,
    input  wire [lambda_pkg::AXIL_ADDR_W-1:0] s_axil_araddr,
    input  wire                               s_axil_arvalid,
    output logic                              s_axil_arready,
    output logic [31:0]                       s_axil_rdata,
    output logic [1:0]                        s_axil_rresp,
    output logic                              s_axil_rvalid,
    input  wire                               s_axil_rready,
    input  wire                               in_valid,
    input  wire [15:0]                        in_mean,
    input  wire [15:0]                        in_var,
    output logic                              out_valid,
    output logic [15:0]                       out_lambda
);

    logic        in_valid_q;
    logic [15:0] mean_q;
    logic [15:0] var_q;
    logic        noise_en;
    logic [15:0] seed_value;
    logic        seed_load;
    logic [15:0] eps_raw;
    logic        sp_valid;
    logic [15:0] sp_data;
    logic        sig_valid;
    logic [15:0] sigma;

    // Input sample register
    always_ff @(posedge clk) begin
        if (reset) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        mean_q <= in_mean;
        var_q  <= in_var;
    end

    lambda_ctrl_regs #(.RESET_SEED(RESET_SEED)) i_ctrl_regs (
        .clk(clk), .reset(reset),
        .s_axil_awaddr(s_axil_awaddr), .s_axil_awvalid(s_axil_awvalid),
        .s_axil_awready(s_axil_awready),
        .s_axil_wdata(s_axil_wdata), .s_axil_wstrb(s_axil_wstrb),
        .s_axil_wvalid(s_axil_wvalid), .s_axil_wready(s_axil_wready),
        .s_axil_bresp(s_axil_bresp), .s_axil_bvalid(s_axil_bvalid),
        .s_axil_bready(s_axil_bready),
        .s_axil_araddr(s_axil_araddr), .s_axil_arvalid(s_axil_arvalid),
        .s_axil_arready(s_axil_arready),
        .s_axil_rdata(s_axil_rdata), .s_axil_rresp(s_axil_rresp),
        .s_axil_rvalid(s_axil_rvalid), .s_axil_rready(s_axil_rready),
        .out_valid(out_valid), .noise_en(noise_en),
        .seed_value(seed_value), .seed_load(seed_load)
    );

    gauss_lfsr #(.RESET_SEED(RESET_SEED)) i_lfsr (
        .clk(clk), .reset(reset), .step(in_valid_q),  // One step per sample
        .seed_load(seed_load), .seed_value(seed_value), .eps_raw(eps_raw)
    );

    softplus_slices i_softplus (
        .clk(clk), .reset(reset), .in_valid(in_valid_q), .data_in(var_q),
        .out_valid(sp_valid), .data_out(sp_data)
    );

    sqrt_pipe i_sqrt (
        .clk(clk), .reset(reset), .in_valid(sp_valid), .data_in(sp_data),
        .out_valid(sig_valid), .data_out(sigma)
    );

    reparam_core i_core (
        .clk(clk), .reset(reset), .in_valid(in_valid_q), .mean_in(mean_q),
        .eps_raw(eps_raw), .noise_en(noise_en), .sig_valid(sig_valid), .sigma(sigma),
        .out_valid(out_valid), .out_lambda(out_lambda)
    );

endmodule

`default_nettype wire

// ==== sim/lambda_layer_asserts.sv ====
//////////////////////////////////////////////////////////////////////
// Bound into lambda_layer_top; expects in_valid low while reset is high
// fail_count is read by the testbench at the end of the run
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lambda_layer_asserts (
    input wire        clk,
    input wire        reset,
    input wire        in_valid,
    input wire        out_valid,
    input wire        seed_load,
    input wire        s_axil_awvalid,
    input wire        s_axil_awready,
    input wire        s_axil_wvalid,
    input wire        s_axil_wready,
    input wire        s_axil_arvalid,
    input wire        s_axil_arready,
    input wire        s_axil_bvalid,
    input wire        s_axil_bready,
    input wire [1:0]  s_axil_bresp,
    input wire        s_axil_rvalid,
    input wire        s_axil_rready,
    input wire [31:0] s_axil_rdata
);
    import lambda_pkg::*;

    int fail_count = 0;

    // Fixed pipeline latency in both directions
    out_follows_in: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> ##TOTAL_LAT out_valid)
    else begin
        fail_count++;
        $error("out_valid missing %0d cycles after in_valid", TOTAL_LAT);
    end

    out_has_source: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(in_valid, TOTAL_LAT))
    else begin
        fail_count++;
        $error("out_valid without a sample %0d cycles earlier", TOTAL_LAT);
    end

    reset_state: assert property (@(posedge clk)
        reset |=> (!out_valid && !s_axil_bvalid && !s_axil_rvalid && !seed_load
                   && s_axil_awready && s_axil_wready && s_axil_arready))
    else begin
        fail_count++;
        $error("outputs not in reset state after reset");
    end

    bvalid_held: assert property (@(posedge clk) disable iff (reset)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp))
    else begin
        fail_count++;
        $error("write response dropped or changed before bready");
    end

    rvalid_held: assert property (@(posedge clk) disable iff (reset)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
    else begin
        fail_count++;
        $error("read data dropped or changed before rready");
    end

    // One transaction at a time, response one cycle after acceptance
    write_accept_resp: assert property (@(posedge clk) disable iff (reset)
        s_axil_awvalid && s_axil_awready && s_axil_wvalid && s_axil_wready
        |=> s_axil_bvalid && !s_axil_awready && !s_axil_wready && !s_axil_arready)
    else begin
        fail_count++;
        $error("accepted write not followed by a pending response alone");
    end

    read_accept_resp: assert property (@(posedge clk) disable iff (reset)
        s_axil_arvalid && s_axil_arready
        |=> s_axil_rvalid && !s_axil_awready && !s_axil_wready && !s_axil_arready)
    else begin
        fail_count++;
        $error("accepted read not followed by a pending response alone");
    end

endmodule

bind lambda_layer_top lambda_layer_asserts i_asserts (.*);

`default_nettype wire

// ==== sim/lambda_layer_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Drives samples back to back at 0.5 ns after the edge, checks each output
// against a reference model; AXI transfers run only with the stream idle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lambda_layer_tb;
    import lambda_pkg::*;

    localparam logic [15:0] RESET_SEED = 16'hACE1;
    localparam int NUM_SAMPLES = 64 + 16 + 160 + 16 + 16;
    localparam int NUM_AXI     = 10;
    localparam int NUM_DRAINS  = 6;
    localparam int STIM_CYCLES = 16 + NUM_SAMPLES + NUM_AXI * 8
                               + NUM_DRAINS * (TOTAL_LAT + 4);
    localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + TOTAL_LAT + 200;

    logic                   clk;
    logic                   reset;
    logic [AXIL_ADDR_W-1:0] s_axil_awaddr;
    logic                   s_axil_awvalid;
    logic                   s_axil_awready;
    logic [31:0]            s_axil_wdata;
    logic [3:0]             s_axil_wstrb;
    logic                   s_axil_wvalid;
    logic                   s_axil_wready;
    logic [1:0]             s_axil_bresp;
    logic                   s_axil_bvalid;
    logic                   s_axil_bready;
    logic [AXIL_ADDR_W-1:0] s_axil_araddr;
    logic                   s_axil_arvalid;
    logic                   s_axil_arready;
    logic [31:0]            s_axil_rdata;
    logic [1:0]             s_axil_rresp;
    logic                   s_axil_rvalid;
    logic                   s_axil_rready;
    logic                   in_valid;
    logic [15:0]            in_mean;
    logic [15:0]            in_var;
    logic                   out_valid;
    logic [15:0]            out_lambda;

    int          seed = 32'h79d8;
    int          err_count = 0;
    int          out_seen = 0;
    int          sent_count = 0;
    int          cycle_count = 0;
    logic [15:0] exp_q[$];
    logic [15:0] expected_head;
    logic [15:0] lfsr_model;
    logic        noise_model;

    lambda_layer_top #(.RESET_SEED(RESET_SEED)) i_lambda_layer_top (.*);

    always #2 clk = ~clk;

    function automatic logic [15:0] rand16();
        int r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_TAPS : 16'h0000);
    endfunction

    function automatic int softplus_ref(input logic [15:0] v);
        int x;
        int idx;
        int lin;
        x = $signed(v);
        if (x < -1024) return 0;      // below -4.0
        if (x >= 1024) return x;      // 4.0 and up passes through
        idx = (x >>> 8) + 4;
        lin = ((int'(SP_SLOPE[idx]) * x) >>> 8) + int'(SP_ICEPT[idx]);
        return (lin < 0) ? 0 : lin;
    endfunction

    function automatic int sqrt_floor(input int v);
        int r;
        r = 0;
        for (int b = 11; b >= 0; b--) begin
            if ((r + (1 << b)) * (r + (1 << b)) <= v) r = r + (1 << b);
        end
        return r;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            err_count++;
            $display("error: %s expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    // Model one sample and queue its lambda
    task automatic push_expected(input logic [15:0] mean, input logic [15:0] var_raw);
        int eps;
        int sig;
        int sum;
        lfsr_model = lfsr_next(lfsr_model);
        eps = $signed(lfsr_model);
        eps = noise_model ? (eps >>> 5) : 0;
        sig = sqrt_floor(softplus_ref(var_raw) << 8);
        sum = $signed(mean) + ((sig * eps) >>> 8);
        if (sum > 32767) exp_q.push_back(16'h7FFF);
        else if (sum < -32768) exp_q.push_back(16'h8000);
        else exp_q.push_back(sum[15:0]);
    endtask

    task automatic send_sample(input logic [15:0] mean, input logic [15:0] var_raw);
        in_valid = 1'b1;
        in_mean  = mean;
        in_var   = var_raw;
        push_expected(mean, var_raw);
        sent_count++;
        @(posedge clk);
        #0.5;
    endtask

    task automatic wait_drain();
        in_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        #0.5;
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = 4'hF;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        @(posedge clk);
        while (!(s_axil_awready && s_axil_wready)) @(posedge clk);
        #0.5;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        @(posedge clk);
        while (!s_axil_bvalid) @(posedge clk);
        #0.5;
        s_axil_bready = 1'b1;  // Late on purpose, bvalid has to wait
        @(posedge clk);
        resp = s_axil_bresp;
        #0.5;
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        @(posedge clk);
        while (!s_axil_arready) @(posedge clk);
        #0.5;
        s_axil_arvalid = 1'b0;
        @(posedge clk);
        while (!s_axil_rvalid) @(posedge clk);
        #0.5;
        s_axil_rready = 1'b1;
        @(posedge clk);
        data = s_axil_rdata;
        resp = s_axil_rresp;
        #0.5;
        s_axil_rready = 1'b0;
    endtask

    // Output monitor, compares against the model queue
    always @(posedge clk) begin
        if (out_valid) begin
            out_seen++;
            if (exp_q.size() == 0) begin
                err_count++;
                $display("error: output sample arrived with none pending");
            end else begin
                expected_head = exp_q.pop_front();
                check_equal("out_lambda", expected_head, out_lambda);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [15:0] r;
        logic [15:0] mn;
        logic [15:0] vr;
        logic [15:0] nxt;
        logic [31:0] rd_data;
        logic [1:0]  resp;
        int          total;
        clk = 1'b0;
        reset = 1'b1;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        in_valid = 1'b0;
        in_mean = '0;
        in_var = '0;
        lfsr_model = RESET_SEED;
        noise_model = 1'b0;
        repeat (16) @(posedge clk);
        #0.5;
        reset = 1'b0;

        axil_read(REG_CTRL, rd_data, resp);
        check_equal("s_axil_rdata", 32'h0, rd_data);

        // Noise off, lambda is the mean
        for (int i = 0; i < 64; i++) send_sample(rand16(), rand16());
        wait_drain();

        axil_write(REG_CTRL, 32'h1, resp);
        check_equal("s_axil_bresp", OKAY, resp);
        noise_model = 1'b1;

        // var below -4.0 gives sigma 0
        for (int i = 0; i < 16; i++) begin
            r = rand16();
            vr = 16'h8000 + (r[14:0] % 15'h7C00);
            send_sample(rand16(), vr);
        end
        wait_drain();

        r = rand16() | 16'h0001;
        axil_write(REG_SEED, {16'h0, r}, resp);
        check_equal("s_axil_bresp", OKAY, resp);
        lfsr_model = r;

        // Every slice, plus 4.0 and up on each tenth sample
        for (int i = 0; i < 160; i++) begin
            r = rand16();
            if (i % 10 == 9) vr = 16'h0400 + (r & 16'h7BFF);
            else vr = 16'((i % 10 - 5) * 256 + r[7:0]);
            send_sample(rand16(), vr);
        end

        // Mean sign follows the coming eps sign so the sum clips
        for (int i = 0; i < 16; i++) begin
            nxt = lfsr_next(lfsr_model);
            mn = nxt[15] ? 16'h8040 : 16'h7FC0;
            vr = 16'h7F00 | rand16() & 16'h00FF;
            send_sample(mn, vr);
        end
        wait_drain();

        axil_write(REG_SEED, 32'h0, resp);
        check_equal("s_axil_bresp", OKAY, resp);
        lfsr_model = RESET_SEED;
        for (int i = 0; i < 16; i++) send_sample(rand16(), rand16());
        wait_drain();
        axil_read(REG_SEED, rd_data, resp);
        check_equal("s_axil_rdata", 32'h0, rd_data);
        axil_read(REG_CTRL, rd_data, resp);
        check_equal("s_axil_rdata", 32'h1, rd_data);
        axil_read(REG_COUNT, rd_data, resp);
        check_equal("s_axil_rdata", sent_count, rd_data);

        // Hole reads zero, count is read only
        axil_read(4'hC, rd_data, resp);
        check_equal("s_axil_rdata", 32'h0, rd_data);
        check_equal("s_axil_rresp", OKAY, resp);
        axil_write(REG_COUNT, 32'h1234, resp);
        check_equal("s_axil_bresp", SLVERR, resp);
        axil_read(REG_COUNT, rd_data, resp);
        check_equal("s_axil_rdata", sent_count, rd_data);
        wait_drain();

        total = err_count + i_lambda_layer_top.i_asserts.fail_count;
        $display("checks done: %0d value errors, %0d assertion failures, %0d outputs",
                 err_count, i_lambda_layer_top.i_asserts.fail_count, out_seen);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/lambda_pkg.sv
hdl/lambda_ctrl_regs.sv
hdl/gauss_lfsr.sv
reparam/softplus_slices.sv
reparam/sqrt_pipe.sv
reparam/reparam_core.sv
hdl/lambda_layer_top.sv
sim/lambda_layer_asserts.sv
sim/lambda_layer_tb.sv
